//--- list.f
+incdir+sim
logic/tpl_adc_pkg.sv
logic/tpl_adc_deframer.sv
logic/tpl_adc_pn_mon.sv
logic/tpl_adc_channel.sv
logic/tpl_adc_core.sv
sim/tb_tpl_adc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the JESD204 ADC transport layer testbench with Verilator and runs it.
# The run fails if the log holds the fail message or lacks the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_tpl_adc \
  -o tb_tpl_adc > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_tpl_adc > sim.log 2>&1 || echo "Simulation exited with an error status"
cat sim.log

grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0

//--- sim/tb_tpl_adc_model.svh
/*
 * Reference model for the JESD204 ADC transport layer testbench
 * Deframing of a lane word, sample formatting and the next pattern sample
 */

`ifndef TB_TPL_ADC_MODEL_SVH
`define TB_TPL_ADC_MODEL_SVH

// Pattern that a lane carries during a test
typedef enum logic [1:0] {
  pat_random,
  pat_ramp,
  pat_pn7,
  pat_pn15
} pat_kind_t;

// Octet 0 is the top byte, each octet pair is one sample above two tail bits
function automatic raw_beat_t deframe_lane(input logic [31:0] word);
  logic [3:0][7:0] octet;
  logic [15:0]     pair;
  raw_beat_t       samples;
  for (int i = 0; i < 4; i++) begin
    octet[i] = word[31-8*i -: 8];
  end
  for (int s = 0; s < samples_per_beat; s++) begin
    pair = {octet[2*s], octet[2*s+1]};
    samples[s] = pair[15:2];
  end
  return samples;
endfunction

function automatic logic [out_width-1:0] format_sample(
  input channel_cfg_t             c,
  input logic [channel_width-1:0] s
);
  logic [channel_width-1:0] v;
  if (!c.dfmt_enable) begin
    return {2'b00, s};
  end
  // Offset binary flips the MSB before any extension
  v = c.dfmt_offset_binary ? (s ^ {1'b1, 13'd0}) : s;
  return c.dfmt_sign_extend ? {{2{v[13]}}, v} : {2'b00, v};
endfunction

function automatic fmt_beat_t format_beat(input channel_cfg_t c, input raw_beat_t r);
  fmt_beat_t f;
  for (int s = 0; s < samples_per_beat; s++) begin
    f[s] = format_sample(c, r[s]);
  end
  return f;
endfunction

// History LSB is the newest stream bit. A PN of order n feeds back the
// bits n and n-1 places back, one new bit per step for 14 steps
function automatic logic [channel_width-1:0] pattern_next(
  input pat_kind_t   kind,
  input logic [27:0] hist
);
  logic [27:0] s;
  int          n;
  if (kind == pat_ramp) begin
    return hist[13:0] + 14'd1;
  end
  s = hist;
  n = (kind == pat_pn7) ? 7 : 15;
  for (int b = 0; b < channel_width; b++) begin
    s = {s[26:0], s[n-1] ^ s[n-2]};
  end
  return s[13:0];
endfunction

`endif

//--- sim/tb_tpl_adc.sv
/*
 * Testbench for the JESD204 ADC receive transport layer
 * Applies a table of tests with random valid gaps and checks data,
 * valid and pattern flags against a reference model
 */

`timescale 1ns/10ps

module tb_tpl_adc;

  import tpl_adc_pkg::*;

  `include "tb_tpl_adc_model.svh"

  localparam int clk_period = 40;
  localparam int reset_cycles = 8;
  localparam int num_rows = 6;

  // One test whose errors flip the MSB of sample 0 on beats first to first+len-1
  typedef struct packed {
    channel_cfg_t [num_channels-1:0] cfg;
    pat_kind_t [num_lanes-1:0]       pat;
    logic [num_lanes-1:0][31:0]      err_first;
    logic [num_lanes-1:0][31:0]      err_len;
    logic [31:0]                     beats;
  } test_row_t;

  // Outputs expected two cycles after a drive
  typedef struct packed {
    logic [num_channels-1:0]      valid;
    fmt_beat_t [num_channels-1:0] data;
    logic [num_channels-1:0]      err;
    logic [num_channels-1:0]      oos;
    logic [num_channels-1:0]      oos_known;
  } expect_t;

  logic                              clk;
  logic                              reset;
  logic                              link_valid;
  link_beat_t                        link_data;
  channel_cfg_t [num_channels-1:0]   cfg;
  logic [num_channels-1:0]           adc_valid;
  fmt_beat_t [num_channels-1:0]      adc_data;
  logic [num_channels-1:0]           pn_err;
  logic [num_channels-1:0]           pn_oos;

  test_row_t            rows [num_rows];
  string                row_name [num_rows];
  logic [num_lanes-1:0] lk_sync;
  logic [num_lanes-1:0] lk_known;
  int                   lk_run [num_lanes];
  int                   limit;

  tpl_adc_core DUT (
    .clk        (clk),
    .reset      (reset),
    .link_valid (link_valid),
    .link_data  (link_data),
    .cfg        (cfg),
    .adc_valid  (adc_valid),
    .adc_data   (adc_data),
    .pn_err     (pn_err),
    .pn_oos     (pn_oos)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic channel_cfg_t make_cfg(logic en, logic se, logic ob, pn_sel_t sel);
    channel_cfg_t c;
    c.dfmt_enable = en;
    c.dfmt_sign_extend = se;
    c.dfmt_offset_binary = ob;
    c.pn_sel = sel;
    return c;
  endfunction

  function automatic test_row_t make_row(channel_cfg_t c0, channel_cfg_t c1, pat_kind_t p0,
                                         pat_kind_t p1, int f0, int l0, int f1, int l1, int n);
    test_row_t row;
    row.cfg[0] = c0;
    row.cfg[1] = c1;
    row.pat[0] = p0;
    row.pat[1] = p1;
    row.err_first[0] = f0;
    row.err_len[0] = l0;
    row.err_first[1] = f1;
    row.err_len[1] = l1;
    row.beats = n;
    return row;
  endfunction

  // ************************************************************
  // Stimulus table
  // ************************************************************

  task automatic fill_table();
    row_name[0] = "raw_zero_extend";
    rows[0] = make_row(make_cfg(1'b0, 1'b0, 1'b0, pn_off), make_cfg(1'b0, 1'b0, 1'b0, pn_off),
                       pat_random, pat_random, 0, 0, 0, 0, 24);
    row_name[1] = "fmt_offset_sign";
    rows[1] = make_row(make_cfg(1'b1, 1'b1, 1'b1, pn_off), make_cfg(1'b1, 1'b0, 1'b0, pn_off),
                       pat_random, pat_random, 0, 0, 0, 0, 24);
    row_name[2] = "fmt_swapped";
    rows[2] = make_row(make_cfg(1'b1, 1'b0, 1'b1, pn_off), make_cfg(1'b1, 1'b1, 1'b0, pn_off),
                       pat_random, pat_random, 0, 0, 0, 0, 24);
    row_name[3] = "ramp_lock";
    rows[3] = make_row(make_cfg(1'b0, 1'b0, 1'b0, pn_ramp), make_cfg(1'b0, 1'b0, 1'b0, pn_ramp),
                       pat_ramp, pat_ramp, 0, 0, 0, 0, 24);
    // Single bad beats at different times, so each pulse must stay on its channel
    row_name[4] = "pn_single_error";
    rows[4] = make_row(make_cfg(1'b0, 1'b0, 1'b0, pn_7), make_cfg(1'b1, 1'b1, 1'b1, pn_15),
                       pat_pn7, pat_pn15, 10, 1, 14, 1, 24);
    row_name[5] = "pn_loss_of_lock";
    rows[5] = make_row(make_cfg(1'b0, 1'b0, 1'b0, pn_15), make_cfg(1'b0, 1'b0, 1'b0, pn_off),
                       pat_pn15, pat_random, 10, 5, 0, 0, 32);
  endtask

  // ************************************************************
  // Compare tasks
  // ************************************************************

  task automatic check_fmt(input string name, input fmt_beat_t expected, input fmt_beat_t actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Formatted data mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic [num_channels-1:0] expected,
                            input logic [num_channels-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %b actual %b", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Flag mismatch");
    end
  endtask

  task automatic check_outputs(input string name, input expect_t e);
    check_flag({name, " adc_valid"}, e.valid, adc_valid);
    for (int ch = 0; ch < num_channels; ch++) begin
      if (e.valid[ch]) begin
        check_fmt($sformatf("%s adc_data[%0d]", name, ch), e.data[ch], adc_data[ch]);
      end
    end
    check_flag({name, " pn_err"}, e.err, pn_err);
    check_flag({name, " pn_oos"}, e.oos & e.oos_known, pn_oos & e.oos_known);
  endtask

  // Lock tracking of one channel. Beat 0 may meet stale history, so the state
  // after beat 3 is open and lock is certain only after beat 4.
  // From then on a run of four same-kind beats flips it
  task automatic update_lock(input int l, input logic [31:0] beat, input logic bad,
                             output logic err);
    err = 1'b0;
    if (cfg[l].pn_sel != pn_off && beat >= 3) begin
      if (beat == 3) begin
        lk_known[l] = 1'b0;
      end else if (beat == 4) begin
        lk_sync[l] = 1'b1;
        lk_run[l] = 0;
        lk_known[l] = 1'b1;
      end else if (bad == lk_sync[l]) begin
        lk_run[l]++;
        if (lk_run[l] == 4) begin
          lk_sync[l] = !lk_sync[l];
          lk_run[l] = 0;
        end else begin
          err = bad;
        end
      end else begin
        lk_run[l] = 0;
      end
    end
  endtask

  // ************************************************************
  // One table row
  // ************************************************************

  task automatic run_row(input int r);
    expect_t                    pipe [$];
    expect_t                    e;
    logic [num_lanes-1:0][27:0] hist;
    logic [31:0]                beat;
    logic [31:0]                word;
    logic [13:0]                s0;
    logic [13:0]                s1;
    logic                       prev_valid;
    logic                       bad;
    logic                       err_bit;
    pat_kind_t                  kind;
    @(posedge clk);
    #2;
    reset = 1'b1;
    // Beats offered during reset must not reach the outputs
    link_valid = 1'b1;
    link_data = {$urandom, $urandom};
    cfg = rows[r].cfg;
    for (int l = 0; l < num_lanes; l++) begin
      // A set LSB keeps the PN seed away from the all-zero lockup
      hist[l] = 28'($urandom) | 28'd1;
      lk_sync[l] = 1'b0;
      lk_run[l] = 0;
      lk_known[l] = 1'b1;
    end
    repeat (reset_cycles) @(posedge clk);
    #2;
    reset = 1'b0;
    link_valid = 1'b0;
    @(posedge clk);
    #1;
    check_flag({row_name[r], " reset adc_valid"}, '0, adc_valid);
    check_flag({row_name[r], " reset pn_err"}, '0, pn_err);
    check_flag({row_name[r], " reset pn_oos"}, '1, pn_oos);
    beat = 0;
    prev_valid = 1'b0;
    while (beat < rows[r].beats || pipe.size() > 0) begin
      @(posedge clk);
      #1;
      // Outputs now belong to the drive two edges back
      if (pipe.size() == 2 || beat >= rows[r].beats) begin
        check_outputs(row_name[r], pipe.pop_front());
      end
      #1;
      e = '0;
      if (beat >= rows[r].beats || (prev_valid && $urandom_range(3) == 0)) begin
        link_valid = 1'b0;
        link_data = {$urandom, $urandom};
        e.oos = ~lk_sync;
        e.oos_known = lk_known;
        prev_valid = 1'b0;
        if (beat < rows[r].beats) begin
          pipe.push_back(e);
        end
      end else begin
        link_valid = 1'b1;
        for (int l = 0; l < num_lanes; l++) begin
          kind = pat_kind_t'(rows[r].pat[l]);
          bad = (rows[r].err_len[l] != 0) && (beat >= rows[r].err_first[l]) &&
                (beat < rows[r].err_first[l] + rows[r].err_len[l]);
          if (kind == pat_random) begin
            word = $urandom;
          end else begin
            s0 = pattern_next(kind, hist[l]);
            s1 = pattern_next(kind, {hist[l][13:0], s0});
            hist[l] = {s0, s1};
            word = {s0, 2'($urandom), s1, 2'($urandom)};
          end
          word[31] = word[31] ^ bad;
          link_data[l] = word;
          e.data[l] = format_beat(cfg[l], deframe_lane(word));
          update_lock(l, beat, bad, err_bit);
          e.err[l] = err_bit;
        end
        e.valid = '1;
        e.oos = ~lk_sync;
        e.oos_known = lk_known;
        prev_valid = 1'b1;
        beat++;
        pipe.push_back(e);
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    link_valid = 1'b0;
    link_data = '0;
    cfg = '0;
    void'($urandom(32'hc01b_1f19));
    fill_table();
    limit = 100;
    for (int r = 0; r < num_rows; r++) begin
      limit += 3 * int'(rows[r].beats);
    end
    fork
      begin
        repeat (limit) @(posedge clk);
        $display("Simulation timed out after %0d cycles", limit);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
      end
    join_none
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

//--- logic/tpl_adc_core.sv
/*
 * JESD204 ADC receive transport layer
 * Deframes the lane words and runs one formatting and
 * pattern checking channel per lane
 */

`timescale 1ns/10ps

module tpl_adc_core (
  input  logic                                                      clk,
  input  logic                                                      reset,
  input  logic                                                      link_valid,
  input  tpl_adc_pkg::link_beat_t                                   link_data,
  input  tpl_adc_pkg::channel_cfg_t [tpl_adc_pkg::num_channels-1:0] cfg,
  output logic [tpl_adc_pkg::num_channels-1:0]                      adc_valid,
  output tpl_adc_pkg::fmt_beat_t [tpl_adc_pkg::num_channels-1:0]    adc_data,
  output logic [tpl_adc_pkg::num_channels-1:0]                      pn_err,
  output logic [tpl_adc_pkg::num_channels-1:0]                      pn_oos
);

  import tpl_adc_pkg::*;

  // Deframed samples, one beat per channel, one cycle after the link
  logic                          raw_valid;
  raw_beat_t [num_channels-1:0]  raw_data;

  // ************************************************************
  // Deframer
  // ************************************************************

  tpl_adc_deframer i_deframer (
    .clk        (clk),
    .reset      (reset),
    .link_valid (link_valid),
    .link_data  (link_data),
    .raw_valid  (raw_valid),
    .raw_data   (raw_data)
  );

  // ************************************************************
  // Channels
  // ************************************************************

  // All channels share the beat valid, since every lane arrives together.
  // Each channel keeps its own copy of the flag, so adc_valid stays per channel
  for (genvar i = 0; i < num_channels; i++) begin : g_channel
    tpl_adc_channel i_channel (
      .clk       (clk),
      .reset     (reset),
      .cfg       (cfg[i]),
      .raw_valid (raw_valid),
      .raw_data  (raw_data[i]),
      .fmt_valid (adc_valid[i]),
      .fmt_data  (adc_data[i]),
      .pn_err    (pn_err[i]),
      .pn_oos    (pn_oos[i])
    );
  end

endmodule

//--- logic/tpl_adc_channel.sv
/*
 * JESD204 ADC channel
 * Formats the samples of one channel into 16 bit words and
 * checks them against the selected test pattern
 */

`timescale 1ns/10ps

module tpl_adc_channel (
  input  logic                      clk,
  input  logic                      reset,
  input  tpl_adc_pkg::channel_cfg_t cfg,
  input  logic                      raw_valid,
  input  tpl_adc_pkg::raw_beat_t    raw_data,
  output logic                      fmt_valid,
  output tpl_adc_pkg::fmt_beat_t    fmt_data,
  output logic                      pn_err,
  output logic                      pn_oos
);

  import tpl_adc_pkg::*;

  fmt_beat_t fmt_d;
  fmt_beat_t fmt_q;
  logic      valid_q;

  // ************************************************************
  // Sample formatting
  // ************************************************************

  // Offset binary turns into two's complement by inverting the MSB.
  // The extension bits copy the new MSB only when sign extension is on.
  // With formatting off the raw bits are zero extended untouched
  function automatic logic [out_width-1:0] fmt_sample(
    input channel_cfg_t              c,
    input logic [channel_width-1:0] s
  );
    logic msb;
    logic ext;
    msb = s[channel_width-1] ^ (c.dfmt_enable & c.dfmt_offset_binary);
    ext = c.dfmt_enable & c.dfmt_sign_extend & msb;
    return {{(out_width-channel_width){ext}}, msb, s[channel_width-2:0]};
  endfunction

  always_comb begin
    for (int s = 0; s < samples_per_beat; s++) begin
      fmt_d[s] = fmt_sample(cfg, raw_data[s]);
    end
  end

  // Second pipeline stage. The words are data only
  always_ff @(posedge clk) begin
    fmt_q <= fmt_d;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= raw_valid;
    end
  end

  assign fmt_data = fmt_q;
  assign fmt_valid = valid_q;

  // ************************************************************
  // Pattern check
  // ************************************************************

  // The monitor sees the raw samples, so the check does not depend on
  // the output format. Its flags line up with the formatted words
  tpl_adc_pn_mon i_pn_mon (
    .clk       (clk),
    .reset     (reset),
    .pn_sel    (cfg.pn_sel),
    .raw_valid (raw_valid),
    .raw_data  (raw_data),
    .pn_err    (pn_err),
    .pn_oos    (pn_oos)
  );

  // The valid chain through deframer and channel is fully reset
  a_valid_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(fmt_valid)
  );

endmodule

//--- logic/tpl_adc_pn_mon.sv
/*
 * JESD204 ADC test pattern monitor
 * Self-synchronizing check of one channel against PN7, PN15 or a ramp,
 * with lock tracking and a per-beat error pulse
 */

`timescale 1ns/10ps

module tpl_adc_pn_mon (
  input  logic                   clk,
  input  logic                   reset,
  input  tpl_adc_pkg::pn_sel_t   pn_sel,
  input  logic                   raw_valid,
  input  tpl_adc_pkg::raw_beat_t raw_data,
  output logic                   pn_err,
  output logic                   pn_oos
);

  import tpl_adc_pkg::*;

  // Recent stream bits with the newest received bit in the LSB.
  // Holds the last sample plus the LSB of the sample before it
  logic [pn_hist_width-1:0] hist_q;

  pn_state_t               state_q;
  pn_state_t               state_d;
  logic [pn_cnt_width-1:0] run_cnt_q;
  logic [pn_cnt_width-1:0] run_cnt_d;
  logic                    pn_err_q;
  logic                    pn_err_d;

  raw_beat_t expected;
  logic      beat_zero;
  logic      beat_match;

  // Next sample of the pattern, derived from the received history.
  // The LFSR runs MSB first, one stream bit per step
  function automatic logic [channel_width-1:0] next_sample(
    input pn_sel_t                  sel,
    input logic [pn_hist_width-1:0] hist
  );
    logic [pn_hist_width-1:0] lfsr;
    logic                     fb;
    lfsr = hist;
    for (int b = 0; b < channel_width; b++) begin
      // x^7+x^6+1 taps bits 7 and 6 back, x^15+x^14+1 bits 15 and 14
      fb = (sel == pn_7) ? (lfsr[6] ^ lfsr[5]) : (lfsr[14] ^ lfsr[13]);
      lfsr = {lfsr[pn_hist_width-2:0], fb};
    end
    if (sel == pn_ramp) begin
      return hist[channel_width-1:0] + 1'b1;
    end
    return lfsr[channel_width-1:0];
  endfunction

  // ************************************************************
  // Expected samples
  // ************************************************************

  // Sample 0 follows the stored history, sample 1 follows sample 0 of
  // the same beat, so both checks run in parallel
  always_comb begin
    expected[0] = next_sample(pn_sel, hist_q);
    expected[1] = next_sample(pn_sel, {hist_q[0], raw_data[0]});
  end

  // An all-zero stream satisfies any LFSR recurrence, so it never
  // counts as a PN match. A ramp legally passes through zero
  assign beat_zero = (raw_data == '0) && (pn_sel != pn_ramp);
  assign beat_match = (raw_data == expected) && !beat_zero;

  always_ff @(posedge clk) begin
    if (raw_valid) begin
      hist_q <= {raw_data[0][0], raw_data[1]};
    end
  end

  // ************************************************************
  // Lock state machine
  // ************************************************************

  // The run counter counts matches while out of sync and mismatches while
  // in sync, and restarts whenever the run is broken or the state flips
  always_comb begin
    state_d = state_q;
    run_cnt_d = run_cnt_q;
    if (raw_valid) begin
      unique case (state_q)
        st_oos: begin
          if (!beat_match) begin
            run_cnt_d = '0;
          end else if (run_cnt_q == pn_cnt_width'(pn_run_len - 1)) begin
            state_d = st_sync;
            run_cnt_d = '0;
          end else begin
            run_cnt_d = run_cnt_q + 1'b1;
          end
        end
        st_sync: begin
          if (beat_match) begin
            run_cnt_d = '0;
          end else if (run_cnt_q == pn_cnt_width'(pn_run_len - 1)) begin
            state_d = st_oos;
            run_cnt_d = '0;
          end else begin
            run_cnt_d = run_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // The mismatch that drops lock is reported by pn_oos, not by pn_err
  assign pn_err_d = raw_valid && !beat_match && (state_q == st_sync) && (state_d == st_sync);

  always_ff @(posedge clk) begin
    if (reset || (pn_sel == pn_off)) begin
      state_q <= st_oos;
      run_cnt_q <= '0;
      pn_err_q <= 1'b0;
    end else begin
      state_q <= state_d;
      run_cnt_q <= run_cnt_d;
      pn_err_q <= pn_err_d;
    end
  end

  assign pn_err = pn_err_q;
  assign pn_oos = (state_q == st_oos);

  // An error is only ever reported while the channel is locked
  a_err_only_in_sync: assert property (
    @(posedge clk) disable iff (reset) pn_err |-> !pn_oos
  );

  // A burst of bad beats keeps pn_err high for at most three cycles,
  // because the fourth bad beat in a row drops lock instead
  a_err_is_pulse: assert property (
    @(posedge clk) disable iff (reset)
      pn_err && $past(pn_err) && $past(pn_err, 2) |=> !pn_err
  );

endmodule

//--- logic/tpl_adc_deframer.sv
/*
 * JESD204 ADC deframer
 * Registers the lane words and regroups their octets into
 * 14 bit samples, one channel per lane
 */

`timescale 1ns/10ps

module tpl_adc_deframer (
  input  logic                                                   clk,
  input  logic                                                   reset,
  input  logic                                                   link_valid,
  input  tpl_adc_pkg::link_beat_t                                link_data,
  output logic                                                   raw_valid,
  output tpl_adc_pkg::raw_beat_t [tpl_adc_pkg::num_channels-1:0] raw_data
);

  import tpl_adc_pkg::*;

  // Lane words captured from the link, first pipeline stage
  link_beat_t lane_q;
  logic       valid_q;

  // The lane words carry data only, the valid flag is the only control bit
  always_ff @(posedge clk) begin
    lane_q <= link_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= link_valid;
    end
  end

  assign raw_valid = valid_q;

  // ************************************************************
  // Octet to sample mapping
  // ************************************************************

  // Octet 0 is the top byte of the lane word and is the MSB octet of
  // sample 0. Each sample occupies a 16 bit word with the converter
  // bits at the top and the two tail bits at the bottom, which are dropped
  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      for (int s = 0; s < samples_per_beat; s++) begin
        raw_data[l][s] = lane_q[l][lane_width-1-s*out_width -: channel_width];
      end
    end
  end

endmodule

//--- logic/tpl_adc_pkg.sv
/*
 * JESD204 ADC transport layer definitions
 * Link geometry, per-channel beat types, the channel configuration
 * and the encodings used by the test pattern monitor
 */

package tpl_adc_pkg;

  // ************************************************************
  // Link geometry
  // ************************************************************

  // Lane n carries channel n, so both counts are the same
  localparam int num_lanes = 2;
  localparam int num_channels = 2;

  // One lane word from the link layer is four octets
  localparam int lane_width = 32;

  // Converter resolution and the number of samples per channel in a beat
  localparam int channel_width = 14;
  localparam int samples_per_beat = 2;

  // Two octets per sample give a 16 bit formatted word
  localparam int out_width = 16;

  // ************************************************************
  // Pattern monitor
  // ************************************************************

  // Consecutive beats needed to enter or to leave pattern lock
  localparam int pn_run_len = 4;
  localparam int pn_cnt_width = $clog2(pn_run_len);

  // Stream history needed to seed the longest LFSR (PN15)
  localparam int pn_hist_width = 15;

  // ************************************************************
  // Types
  // ************************************************************

  // Lane words as they arrive from the link layer, lane 0 in the low word
  typedef logic [num_lanes-1:0][lane_width-1:0] link_beat_t;

  // Samples of one channel, sample 0 (the older one) at index 0
  typedef logic [samples_per_beat-1:0][channel_width-1:0] raw_beat_t;
  typedef logic [samples_per_beat-1:0][out_width-1:0] fmt_beat_t;

  typedef enum logic [1:0] {
    pn_off  = 2'd0,
    pn_7    = 2'd1,
    pn_15   = 2'd2,
    pn_ramp = 2'd3
  } pn_sel_t;

  // Static setup of one channel
  typedef struct packed {
    logic    dfmt_enable;
    logic    dfmt_sign_extend;
    logic    dfmt_offset_binary;
    pn_sel_t pn_sel;
  } channel_cfg_t;

  typedef enum logic {
    st_oos  = 1'b0,
    st_sync = 1'b1
  } pn_state_t;

endpackage
